/* hdl/button_debouncer.sv */
// Start button conditioner; instantiate once per button to get one clean pulse per press
module button_debouncer
#(
	parameter int debounce_cycles = starship_pkg::DEBOUNCE_CYCLES_DEFAULT
)
(
	input  logic board_clk,
	input  logic Reset,
	input  logic btn,         // Raw, asynchronous
	output logic press_pulse  // One cycle per accepted press
);

	localparam int count_width = $clog2(debounce_cycles + 1);

	logic                   sync_ff1;
	logic                   sync_ff2;
	logic                   armed;        // Cleared after a pulse until release
	logic [count_width-1:0] stable_count;

	// ----------------------------------------
	// Two-flop synchronizer
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			sync_ff1 <= 1'b0;
			sync_ff2 <= 1'b0;
		end
		else
		begin
			sync_ff1 <= btn;
			sync_ff2 <= sync_ff1;
		end
	end

	// ----------------------------------------
	// Stable-high counter and pulse
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			stable_count <= '0;
			armed        <= 1'b1;
			press_pulse  <= 1'b0;
		end
		else
		begin
			press_pulse <= 1'b0;
			if (!sync_ff2)
			begin
				// Any low sample restarts the count and rearms
				stable_count <= '0;
				armed        <= 1'b1;
			end
			else if (armed)
			begin
				if (stable_count == count_width'(debounce_cycles - 1))
				begin
					press_pulse  <= 1'b1;
					armed        <= 1'b0; // Held button gives no repeat
					stable_count <= '0;
				end
				else
					stable_count <= stable_count + 1'b1;
			end
		end
	end

endmodule

/* hdl/game_fsm.sv */
// Game state machine Init, Play, Game Over; steps on start presses and hull breach
module game_fsm
(
	input  logic board_clk,
	input  logic Reset,
	input  logic start_pulse,   // Debounced start press
	input  logic hull_breach,   // Game-over vote, level
	output logic play,          // High exactly in Play
	output logic new_game,      // One cycle at each game start
	output logic led_init,
	output logic led_play,
	output logic led_gameover
);

	import starship_pkg::*;

	game_state_t state;
	game_state_t state_next;

	// ----------------------------------------
	// Next state
	always_comb
	begin
		state_next = state;
		case (state)
			GS_INIT:
				if (start_pulse)
					state_next = GS_PLAY;
			GS_PLAY:
				if (hull_breach)
					state_next = GS_GAMEOVER;
			GS_GAMEOVER:
				if (start_pulse)
					state_next = GS_INIT;
			default:
				state_next = GS_INIT; // Unused code recovers to Init
		endcase
	end

	// ----------------------------------------
	// State, LEDs and start pulse
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			state        <= GS_INIT;
			led_init     <= 1'b1;
			led_play     <= 1'b0;
			led_gameover <= 1'b0;
			new_game     <= 1'b0;
		end
		else
		begin
			state        <= state_next;
			// Decoded from the next state so LEDs line up with state
			led_init     <= (state_next == GS_INIT);
			led_play     <= (state_next == GS_PLAY);
			led_gameover <= (state_next == GS_GAMEOVER);
			new_game     <= (state == GS_INIT) && start_pulse; // High in first Play cycle
		end
	end

	assign play = (state == GS_PLAY);

endmodule

/* hdl/game_timer.sv */
// Play-time clock; counts decimal seconds and minutes while the game is in play
module game_timer
#(
	parameter int cycles_per_sec = starship_pkg::CYCLES_PER_SEC_DEFAULT
)
(
	input  logic                    board_clk,
	input  logic                    Reset,
	input  logic                    play,      // Count enable
	input  logic                    new_game,  // Clears the time
	output starship_pkg::hex_digit_t sec_ones,
	output starship_pkg::hex_digit_t sec_tens,
	output starship_pkg::hex_digit_t minutes
);

	localparam int count_width = (cycles_per_sec > 1) ? $clog2(cycles_per_sec) : 1;

	logic [count_width-1:0] cycle_count;
	logic                   sec_tick;     // Last cycle of a second
	logic                   ones_wrap;
	logic                   tens_wrap;

	// ----------------------------------------
	// One-second divider
	assign sec_tick  = play && (cycle_count == count_width'(cycles_per_sec - 1));
	assign ones_wrap = (sec_ones == 4'd9);
	assign tens_wrap = (sec_tens == 4'd5) && ones_wrap; // Only after x:59

	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
			cycle_count <= '0;
		else if (new_game)
			cycle_count <= '0;
		else if (sec_tick)
			cycle_count <= '0;
		else if (play)
			cycle_count <= cycle_count + 1'b1;
	end

	// ----------------------------------------
	// Seconds and minutes digits
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			sec_ones <= 4'd0;
			sec_tens <= 4'd0;
			minutes  <= 4'd0;
		end
		else if (new_game)
		begin
			sec_ones <= 4'd0;
			sec_tens <= 4'd0;
			minutes  <= 4'd0;
		end
		else if (sec_tick)
		begin
			if (ones_wrap)
				sec_ones <= 4'd0;
			else
				sec_ones <= sec_ones + 4'd1;

			// Tens step on the ones carry
			if (tens_wrap)
				sec_tens <= 4'd0;
			else if (ones_wrap)
				sec_tens <= sec_tens + 4'd1;

			if (tens_wrap)
				minutes <= minutes + 4'd1; // 15 wraps to 0
		end
	end

endmodule

/* hdl/ssd_scanner.sv */
// Eight-digit seven-segment scanner; selects a digit per scan slot and decodes it to cathodes
module ssd_scanner
#(
	parameter int scan_bits = starship_pkg::SCAN_BITS_DEFAULT
)
(
	input  logic                                board_clk,
	input  logic                                Reset,
	input  starship_pkg::hex_digit_t            switch_digit,
	input  starship_pkg::hex_digit_t            sec_ones,
	input  starship_pkg::hex_digit_t            sec_tens,
	input  starship_pkg::hex_digit_t            minutes,
	output logic [starship_pkg::NUM_DIGITS-1:0] an,   // Active low
	output starship_pkg::segments_t             seg
);

	import starship_pkg::*;

	logic [scan_bits-1:0] scan_count;
	digit_index_t         digit_sel;
	hex_digit_t           digit_value;
	logic                 digit_lit;    // Low for the unused positions
	segments_t            glyph;

	// ----------------------------------------
	// Free-running scan counter
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
			scan_count <= '0;
		else
			scan_count <= scan_count + 1'b1;
	end

	assign digit_sel = scan_count[scan_bits-1 -: DIGIT_SEL_BITS];

	// One anode low at a time
	assign an = ~(NUM_DIGITS'(1) << digit_sel);

	// ----------------------------------------
	// Digit selection
	always_comb
	begin
		digit_value = 4'd0;
		digit_lit   = 1'b1;
		case (digit_sel)
			DIGIT_SWITCHES: digit_value = switch_digit;
			DIGIT_SEC_ONES: digit_value = sec_ones;
			DIGIT_SEC_TENS: digit_value = sec_tens;
			DIGIT_MINUTES:  digit_value = minutes;
			default:        digit_lit   = 1'b0;      // Combo digit and spares stay dark
		endcase
	end

	// ----------------------------------------
	// Hex to segments, bits a..g then Dp, Dp lit
	always_comb
	begin
		case (digit_value)
			4'h0: glyph = 8'b0000_0010;
			4'h1: glyph = 8'b1001_1110;
			4'h2: glyph = 8'b0010_0100;
			4'h3: glyph = 8'b0000_1100;
			4'h4: glyph = 8'b1001_1000;
			4'h5: glyph = 8'b0100_1000;
			4'h6: glyph = 8'b0100_0000;
			4'h7: glyph = 8'b0001_1110;
			4'h8: glyph = 8'b0000_0000;
			4'h9: glyph = 8'b0000_1000;
			4'hA: glyph = 8'b0001_0000;
			4'hB: glyph = 8'b1100_0000; // Lower-case b
			4'hC: glyph = 8'b0110_0010;
			4'hD: glyph = 8'b1000_0100; // Lower-case d
			4'hE: glyph = 8'b0110_0000;
			default: glyph = 8'b0111_0000; // F
		endcase
	end

	assign seg = digit_lit ? glyph : SEGMENTS_BLANK;

endmodule

/* hdl/starship_pkg.sv */
// Shared constants and types for the starship board; compile first and import where needed
package starship_pkg;

	// ----------------------------------------
	// Game state machine encoding
	typedef enum logic [1:0]
	{
		GS_INIT     = 2'b00,
		GS_PLAY     = 2'b01,
		GS_GAMEOVER = 2'b10
	} game_state_t;

	// ----------------------------------------
	// Display digits and cathodes
	localparam int NUM_DIGITS = 8;
	localparam int DIGIT_SEL_BITS = $clog2(NUM_DIGITS); // Digit index width

	typedef logic [3:0] hex_digit_t; // One displayed hex value
	typedef logic [DIGIT_SEL_BITS-1:0] digit_index_t;

	// Cathodes a, b, c, d, e, f, g, Dp from msb down, active low
	typedef logic [7:0] segments_t;

	localparam segments_t SEGMENTS_BLANK = 8'hFF; // All cathodes off

	// Positions on the eight-digit display
	localparam digit_index_t DIGIT_SWITCHES = 0;
	localparam digit_index_t DIGIT_SEC_ONES = 4;
	localparam digit_index_t DIGIT_SEC_TENS = 5;
	localparam digit_index_t DIGIT_MINUTES  = 6;

	// ----------------------------------------
	// Board timing defaults, 100 MHz clock
	localparam int CYCLES_PER_SEC_DEFAULT = 100_000_000;

	// About 10 ms of stable press
	localparam int DEBOUNCE_CYCLES_DEFAULT = 2**20;

	// Top three bits pick the digit, roughly 760 Hz per digit
	localparam int SCAN_BITS_DEFAULT = 17;

endpackage

/* hdl/starship_top.sv */
// Board top level for the starship game; ties the start button, game control, timer and display
module starship_top
#(
	parameter int cycles_per_sec  = starship_pkg::CYCLES_PER_SEC_DEFAULT,
	parameter int debounce_cycles = starship_pkg::DEBOUNCE_CYCLES_DEFAULT,
	parameter int scan_bits       = starship_pkg::SCAN_BITS_DEFAULT
)
(
	input  logic                                board_clk,
	input  logic                                Reset,
	input  logic                                btn_up,       // Start button, raw
	input  logic                                hull_breach,  // Game-over level
	input  starship_pkg::hex_digit_t            sw,
	output logic                                led_init,
	output logic                                led_play,
	output logic                                led_gameover,
	output logic [starship_pkg::NUM_DIGITS-1:0] an,
	output starship_pkg::segments_t             seg
);

	import starship_pkg::*;

	logic       start_pulse;
	logic       play;
	logic       new_game;
	hex_digit_t switch_digit;
	hex_digit_t sec_ones;
	hex_digit_t sec_tens;
	hex_digit_t minutes;

	// ----------------------------------------
	// Switches into the display digit
	always_ff @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
			switch_digit <= 4'd0;
		else
			switch_digit <= sw;
	end

	// ----------------------------------------
	// Start path
	button_debouncer #(.debounce_cycles(debounce_cycles)) u_start_debouncer
	(
		.board_clk   (board_clk),
		.Reset       (Reset),
		.btn         (btn_up),
		.press_pulse (start_pulse)
	);

	game_fsm u_game_fsm
	(
		.board_clk    (board_clk),
		.Reset        (Reset),
		.start_pulse  (start_pulse),
		.hull_breach  (hull_breach),
		.play         (play),
		.new_game     (new_game),
		.led_init     (led_init),
		.led_play     (led_play),
		.led_gameover (led_gameover)
	);

	game_timer #(.cycles_per_sec(cycles_per_sec)) u_game_timer
	(
		.board_clk (board_clk),
		.Reset     (Reset),
		.play      (play),
		.new_game  (new_game),
		.sec_ones  (sec_ones),
		.sec_tens  (sec_tens),
		.minutes   (minutes)
	);

	// ----------------------------------------
	// Display path
	ssd_scanner #(.scan_bits(scan_bits)) u_ssd_scanner
	(
		.board_clk    (board_clk),
		.Reset        (Reset),
		.switch_digit (switch_digit),
		.sec_ones     (sec_ones),
		.sec_tens     (sec_tens),
		.minutes      (minutes),
		.an           (an),
		.seg          (seg)
	);

endmodule

/* project.f */
hdl/starship_pkg.sv
hdl/button_debouncer.sv
hdl/game_fsm.sv
hdl/game_timer.sv
hdl/ssd_scanner.sv
hdl/starship_top.sv
testbench/tb_starship_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the starship testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_starship_top -f project.f -o sim_starship

output=$(./obj_dir/sim_starship)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
	exit 0
else
	exit 1
fi

/* testbench/tb_starship_top.sv */
// Self-checking testbench for the starship board top level; build it with the project file list
module tb_starship_top;

	timeunit 1ns;
	timeprecision 1ps;

	import starship_pkg::*;

	localparam int CPS        = 40;
	localparam int DEBOUNCE   = 8;
	localparam int SCAN       = 6;
	localparam int WAIT_LIMIT = 200;   // Cycles allowed for a single wait

	logic                  board_clk;
	logic                  Reset;
	logic                  btn_up;
	logic                  hull_breach;
	hex_digit_t            sw;
	logic                  led_init;
	logic                  led_play;
	logic                  led_gameover;
	logic [NUM_DIGITS-1:0] an;
	segments_t             seg;

	hex_digit_t sw_q;        // Switch value as the DUT holds it
	int         model_sec;   // Expected game time in seconds
	int         model_cnt;
	logic       prev_play;
	logic       mon_en;
	string      cur_test;
	int         test_errs;
	int         pass_count;
	int         fail_count;
	int         seed;

	starship_top #(.cycles_per_sec(CPS), .debounce_cycles(DEBOUNCE), .scan_bits(SCAN)) UUT
	(
		.board_clk    (board_clk),
		.Reset        (Reset),
		.btn_up       (btn_up),
		.hull_breach  (hull_breach),
		.sw           (sw),
		.led_init     (led_init),
		.led_play     (led_play),
		.led_gameover (led_gameover),
		.an           (an),
		.seg          (seg)
	);

	always #10 board_clk = ~board_clk;

	// Hard limit on the whole run
	initial
	begin
		#1_000_000;
		$display("Simulation ran past its time limit");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ----------------------------------------
	// Reference model of the game time
	always @(posedge board_clk or posedge Reset)
	begin
		if (Reset)
		begin
			model_sec <= 0;
			model_cnt <= 0;
			prev_play <= 1'b0;
			sw_q      <= 4'd0;
		end
		else
		begin
			sw_q      <= sw;
			prev_play <= led_play;
			if (led_play && !prev_play)
			begin
				model_sec <= 0; // First Play cycle clears the time
				model_cnt <= 0;
			end
			else if (led_play)
			begin
				if (model_cnt == CPS - 1)
				begin
					model_cnt <= 0;
					model_sec <= (model_sec + 1) % 960; // Minutes wrap after 15
				end
				else
					model_cnt <= model_cnt + 1;
			end
		end
	end

	function automatic hex_digit_t ref_digit(input int sec, input int pos);
		case (pos)
			DIGIT_SEC_ONES: return hex_digit_t'(sec % 10);
			DIGIT_SEC_TENS: return hex_digit_t'((sec % 60) / 10);
			default:        return hex_digit_t'((sec / 60) % 16);
		endcase
	endfunction

	// Glyphs written as lit segments a..g, Dp, then inverted for the cathodes
	function automatic segments_t hex_glyph(input hex_digit_t d);
		logic [7:0] lit;
		case (d)
			4'h0: lit = 8'b1111_1101;
			4'h1: lit = 8'b0110_0001;
			4'h2: lit = 8'b1101_1011;
			4'h3: lit = 8'b1111_0011;
			4'h4: lit = 8'b0110_0111;
			4'h5: lit = 8'b1011_0111;
			4'h6: lit = 8'b1011_1111;
			4'h7: lit = 8'b1110_0001;
			4'h8: lit = 8'b1111_1111;
			4'h9: lit = 8'b1111_0111;
			4'hA: lit = 8'b1110_1111;
			4'hB: lit = 8'b0011_1111;
			4'hC: lit = 8'b1001_1101;
			4'hD: lit = 8'b0111_1011;
			4'hE: lit = 8'b1001_1111;
			default: lit = 8'b1000_1111;
		endcase
		return ~lit;
	endfunction

	function automatic bit decode_seg(input segments_t s, output hex_digit_t d);
		d = 4'd0;
		for (int i = 0; i < 16; i++)
		begin
			if (hex_glyph(hex_digit_t'(i)) == s)
			begin
				d = hex_digit_t'(i);
				return 1'b1;
			end
		end
		return 1'b0; // Blank or unknown pattern
	endfunction

	function automatic segments_t expected_seg(input int k);
		if (k == DIGIT_SWITCHES)
			return hex_glyph(sw_q);
		if (k == DIGIT_SEC_ONES || k == DIGIT_SEC_TENS || k == DIGIT_MINUTES)
			return hex_glyph(ref_digit(model_sec, k));
		return SEGMENTS_BLANK;
	endfunction

	// ----------------------------------------
	// Compare tasks and test bookkeeping
	task automatic check_digit(input string what, input hex_digit_t exp, input hex_digit_t act);
		if (exp !== act)
		begin
			$display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_segments(input string what, input segments_t exp, input segments_t act);
		if (exp !== act)
		begin
			$display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_level(input string what, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errs++;
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0)
		begin
			$display("PASS %s", cur_test);
			pass_count++;
		end
		else
		begin
			$display("FAIL %s with %0d errors", cur_test, test_errs);
			fail_count++;
		end
	endtask

	// Every cycle, the lit digit must match the reference
	always @(negedge board_clk)
	begin : display_monitor
		int k;
		k = 0;
		if (mon_en && !Reset && $countones(~an) == 1)
		begin
			for (int i = 0; i < NUM_DIGITS; i++)
				if (!an[i])
					k = i;
			check_segments($sformatf("monitor digit %0d", k), expected_seg(k), seg);
		end
	end

	// ----------------------------------------
	// Waits and stimulus
	task automatic wait_slot(input int k, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge board_clk);
			if (an[k] == 1'b0)
			begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok)
			report_problem($sformatf("timed out waiting for digit %0d to light", k));
	endtask

	task automatic wait_led(input int sel);
		bit ok;
		ok = 1'b0;
		for (int n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge board_clk);
			if ((sel == 0 && led_init) || (sel == 1 && led_play) || (sel == 2 && led_gameover))
			begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok)
			report_problem($sformatf("timed out waiting for state LED %0d", sel));
	endtask

	task automatic wait_seconds(input int target);
		bit ok;
		ok = 1'b0;
		for (int n = 0; n < 70 * CPS; n++)
		begin
			@(negedge board_clk);
			if (model_sec == target)
			begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok)
			report_problem($sformatf("game time never reached %0d seconds", target));
	endtask

	// Press held well past the debounce time, then released
	task automatic press_start();
		@(posedge board_clk);
		#2 btn_up = 1'b1;
		repeat (DEBOUNCE * 3) @(posedge board_clk);
		#2 btn_up = 1'b0;
		repeat (4) @(posedge board_clk);
	endtask

	// Reads minutes, tens and ones within one second of game time
	task automatic read_time(output hex_digit_t ones, output hex_digit_t tens,
		output hex_digit_t mins);
		bit ok;
		bit lit_o;
		bit lit_t;
		bit lit_m;
		int s0;
		ones = 4'd0;
		tens = 4'd0;
		mins = 4'd0;
		for (int tries = 0; tries < 10; tries++)
		begin
			wait_slot(DIGIT_SEC_ONES, ok);
			if (!ok)
				return;
			s0 = model_sec;
			lit_o = decode_seg(seg, ones);
			wait_slot(DIGIT_SEC_TENS, ok);
			lit_t = decode_seg(seg, tens);
			wait_slot(DIGIT_MINUTES, ok);
			lit_m = decode_seg(seg, mins);
			if (model_sec == s0)
			begin
				if (!(lit_o && lit_t && lit_m))
					report_problem("a time digit was blank");
				check_digit("sec ones", ref_digit(s0, DIGIT_SEC_ONES), ones);
				check_digit("sec tens", ref_digit(s0, DIGIT_SEC_TENS), tens);
				check_digit("minutes", ref_digit(s0, DIGIT_MINUTES), mins);
				return;
			end
		end
		report_problem("could not read a steady time from the display");
	endtask

	// ----------------------------------------
	// Test sequence
	initial
	begin : main_sequence
		hex_digit_t o1;
		hex_digit_t t1;
		hex_digit_t m1;
		hex_digit_t o2;
		hex_digit_t t2;
		hex_digit_t m2;
		bit         ok;
		bit         lit;
		int         prev;
		int         cur;
		int         carries;

		seed        = $urandom(32'h3171_4f2e);
		board_clk   = 1'b0;
		Reset       = 1'b1;
		btn_up      = 1'b0;
		hull_breach = 1'b0;
		sw          = 4'd0;
		mon_en      = 1'b0;
		pass_count  = 0;
		fail_count  = 0;
		repeat (2) @(posedge board_clk);
		#2 Reset = 1'b0;
		mon_en = 1'b1;

		start_test("reset_state");
		@(negedge board_clk);
		check_level("led_init", 1'b1, led_init);
		check_level("led_play", 1'b0, led_play);
		check_level("led_gameover", 1'b0, led_gameover);
		read_time(o1, t1, m1);
		check_digit("time ones", 4'd0, o1);
		check_digit("time tens", 4'd0, t1);
		check_digit("time minutes", 4'd0, m1);
		end_test();

		start_test("scan_positions");
		repeat (3)
		begin
			@(posedge board_clk);
			#2 sw = hex_digit_t'($urandom % 16);
			repeat (2) @(posedge board_clk);
			for (int k = 0; k < NUM_DIGITS; k++)
			begin
				wait_slot(k, ok);
				check_level($sformatf("one anode at %0d", k), 1'b1, $countones(~an) == 1);
				check_segments($sformatf("digit %0d", k), expected_seg(k), seg);
			end
		end
		end_test();

		start_test("count_up");
		press_start();
		wait_led(1);
		prev    = -1;
		carries = 0;
		repeat (12)
		begin
			read_time(o2, t2, m2);
			cur = m2 * 60 + t2 * 10 + o2;
			if (cur < prev)
				report_problem("displayed time went backwards");
			if (prev >= 0 && t2 != t1)
			begin
				// Tens only step when the ones wrap past 9
				check_digit("tens after carry", t1 + 4'd1, t2);
				if (o2 >= o1)
					report_problem("ones digit did not wrap on the tens carry");
				carries++;
			end
			prev = cur;
			o1 = o2;
			t1 = t2;
		end
		if (carries == 0)
			report_problem("no tens carry was seen on the display");
		end_test();

		start_test("minute_rollover");
		wait_seconds(59);
		wait_seconds(60);
		read_time(o1, t1, m1);
		check_digit("minutes", 4'd1, m1);
		check_digit("sec tens", 4'd0, t1);
		end_test();

		start_test("hull_breach");
		@(posedge board_clk);
		#2 hull_breach = 1'b1;
		wait_led(2);
		check_level("led_play", 1'b0, led_play);
		read_time(o1, t1, m1);
		repeat (5 * CPS) @(posedge board_clk);
		read_time(o2, t2, m2);
		check_digit("frozen ones", o1, o2);
		check_digit("frozen tens", t1, t2);
		check_digit("frozen minutes", m1, m2);
		end_test();

		start_test("new_game");
		press_start();
		wait_led(0);
		// Breach clears before the next press so the new game keeps running
		@(posedge board_clk);
		#2 hull_breach = 1'b0;
		btn_up = 1'b1;
		wait_led(1);
		wait_slot(DIGIT_SEC_ONES, ok);
		lit = decode_seg(seg, o1);
		wait_slot(DIGIT_SEC_TENS, ok);
		lit = decode_seg(seg, t1) && lit;
		wait_slot(DIGIT_MINUTES, ok);
		lit = decode_seg(seg, m1) && lit;
		@(posedge board_clk);
		#2 btn_up = 1'b0;
		if (!lit)
			report_problem("a time digit was blank");
		check_digit("minutes", 4'd0, m1);
		check_digit("sec tens", 4'd0, t1);
		if (o1 > 4'd1)
			report_problem("new game did not start from 0:00");
		end_test();

		mon_en = 1'b0;
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
